/* Makefile */
# Verilator build and run of the NES video testbench

VERILATOR ?= verilator
TOP       ?= nes_video_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass message appears on a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/osd_pkg.sv
rtl/nes_palette.sv
rtl/line_buffer.sv
rtl/line_capture.sv
rtl/video_timing.sv
rtl/line_playout.sv
rtl/osd_overlay.sv
rtl/nes_video.sv
test/nes_video_tb.sv

/* rtl/line_buffer.sv */
// --------------------------------------------------------------------------
// line buffer: one PPU line of palette indices, registered read
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module line_buffer (
	input  logic       clk,
	input  logic       we,
	input  logic [7:0] waddr,
	input  logic [5:0] wdata,
	input  logic [7:0] raddr,
	output logic [5:0] rdata
);

	logic [5:0] mem [0:255];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];  // one cycle read latency
	end

endmodule

/* rtl/line_capture.sv */
// --------------------------------------------------------------------------
// line capture: steers PPU pixels into the buffer chosen by line parity
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module line_capture
	import video_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  ppu_pixel_t               ppu,
	output logic [`LINE_BUFFERS-1:0] we,
	output logic [7:0]               waddr,
	output logic [5:0]               wdata
);

	logic [7:0] last_line;  // line of the previous write
	logic       have_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			we        <= '0;
			have_last <= 1'b0;
		end else begin
			for (int i = 0; i < `LINE_BUFFERS; i++) begin
				we[i] <= ppu.valid && (ppu.line[0] == 1'(i));  // even lines to 0, odd to 1
			end
			if (ppu.valid) begin
				have_last <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ppu.valid) begin
			waddr     <= ppu.x;
			wdata     <= ppu.index;
			last_line <= ppu.line;
		end
	end

	// waddr holds the x of the previous pixel written
	a_x_order: assert property (
		@(posedge clk) disable iff (reset)
		(ppu.valid && have_last && ppu.line == last_line) |-> (ppu.x >= waddr)
	);

endmodule

/* rtl/line_playout.sv */
// --------------------------------------------------------------------------
// line playout: reads each stored pixel twice on two VGA lines
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module line_playout
	import video_pkg::*;
(
	input  logic                          clk,
	input  raster_t                       raster_in,
	input  logic [`LINE_BUFFERS-1:0][5:0] rdata,
	output logic [7:0]                    raddr,
	output logic [5:0]                    index,
	output raster_t                       raster_out
);

	logic sel;  // buffer whose read is in flight

	// h/2 repeats every stored pixel
	assign raddr = raster_in.h[8:1];

	always_ff @(posedge clk) begin
		sel        <= raster_in.v[1];  // (v/2)[0], each PPU line on two VGA lines
		raster_out <= raster_in;
	end

	assign index = rdata[sel];

endmodule

/* rtl/nes_palette.sv */
// --------------------------------------------------------------------------
// NES palette: 6-bit colour index to RGB555, registered
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module nes_palette
	import video_pkg::*;
(
	input  logic       clk,
	input  logic [5:0] index,
	output rgb555_t    rgb
);

	logic [14:0] colour;

	always_comb begin
		case (index)
			6'h00: colour = 15'h3DEF;
			6'h01: colour = 15'h7C00;
			6'h02: colour = 15'h5C00;
			6'h03: colour = 15'h5CA8;
			6'h04: colour = 15'h4012;
			6'h05: colour = 15'h1015;
			6'h06: colour = 15'h0055;
			6'h07: colour = 15'h0051;
			6'h08: colour = 15'h00CA;
			6'h09: colour = 15'h01E0;
			6'h0A: colour = 15'h01A0;
			6'h0B: colour = 15'h0160;
			6'h0C: colour = 15'h2D00;
			6'h10: colour = 15'h5EF7;
			6'h11: colour = 15'h7DE0;
			6'h12: colour = 15'h7D60;
			6'h13: colour = 15'h7D0D;
			6'h14: colour = 15'h641B;
			6'h15: colour = 15'h2C1C;
			6'h16: colour = 15'h00FF;
			6'h17: colour = 15'h097C;
			6'h18: colour = 15'h01F5;
			6'h19: colour = 15'h02E0;
			6'h1A: colour = 15'h02A0;
			6'h1B: colour = 15'h22A0;
			6'h1C: colour = 15'h4620;
			6'h20: colour = 15'h7FFF;
			6'h21: colour = 15'h7EE7;
			6'h22: colour = 15'h7E2D;
			6'h23: colour = 15'h7DF3;
			6'h24: colour = 15'h7DFF;
			6'h25: colour = 15'h4D7F;
			6'h26: colour = 15'h2DFF;
			6'h27: colour = 15'h229F;
			6'h28: colour = 15'h02FF;
			6'h29: colour = 15'h0FF7;
			6'h2A: colour = 15'h2B6B;
			6'h2B: colour = 15'h4FEB;
			6'h2C: colour = 15'h6FA0;
			6'h2D: colour = 15'h3DEF;
			6'h30: colour = 15'h7FFF;
			6'h31: colour = 15'h7F94;
			6'h32: colour = 15'h7EF7;
			6'h33: colour = 15'h7EFB;
			6'h34: colour = 15'h7EFF;
			6'h35: colour = 15'h629F;
			6'h36: colour = 15'h5B5E;
			6'h37: colour = 15'h579F;
			6'h38: colour = 15'h3F7F;
			6'h39: colour = 15'h3FFB;
			6'h3A: colour = 15'h5FF7;
			6'h3B: colour = 15'h6FF7;
			6'h3C: colour = 15'h7FE0;
			6'h3D: colour = 15'h7F7F;
			default: colour = 15'h0000;  // the black columns x0D..x0F
		endcase
	end

	always_ff @(posedge clk) begin
		rgb <= rgb555_t'(colour);
	end

endmodule

/* rtl/nes_video.sv */
// --------------------------------------------------------------------------
// NES video output: PPU line capture, scan doubler, palette and OSD to VGA
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module nes_video
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       frame_start,
	input  logic       sck,
	input  logic       ss,
	input  logic       sdi,
	input  ppu_pixel_t ppu,
	output logic       hsync,
	output logic       vsync,
	output rgb555_t    rgb
);

	logic [`LINE_BUFFERS-1:0]      we;
	logic [7:0]                    waddr;
	logic [5:0]                    wdata;
	logic [7:0]                    raddr;
	logic [`LINE_BUFFERS-1:0][5:0] rdata;
	logic [5:0]                    index;
	raster_t                       raster;
	raster_t                       raster_play;
	raster_t                       raster_pal;  // aligned with palette output
	rgb555_t                       pal_rgb;

	line_capture i_capture (.clk, .reset, .ppu, .we, .waddr, .wdata);

	for (genvar gi = 0; gi < `LINE_BUFFERS; gi++) begin : g_buf
		line_buffer i_buf (
			.clk,
			.we    (we[gi]),
			.waddr,
			.wdata,
			.raddr,
			.rdata (rdata[gi])
		);
	end

	video_timing i_timing (.clk, .reset, .frame_start, .raster);

	line_playout i_playout (
		.clk, .raster_in (raster), .rdata, .raddr, .index, .raster_out (raster_play)
	);

	nes_palette i_palette (.clk, .index, .rgb (pal_rgb));

	always_ff @(posedge clk) begin
		if (reset) begin
			raster_pal <= '{h: '0, v: '0, visible: 1'b0, hsync: 1'b1, vsync: 1'b1};
		end else begin
			raster_pal <= raster_play;
		end
	end

	osd_overlay i_osd (
		.clk, .reset, .sck, .ss, .sdi,
		.raster_in (raster_pal), .rgb_in (pal_rgb), .rgb, .hsync, .vsync
	);

endmodule

/* rtl/osd_overlay.sv */
// --------------------------------------------------------------------------
// OSD overlay: serial loader, 64 x 16 bitmap and window mix on RGB555
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module osd_overlay
	import video_pkg::*;
	import osd_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    sck,
	input  logic    ss,
	input  logic    sdi,
	input  raster_t raster_in,
	input  rgb555_t rgb_in,
	output rgb555_t rgb,
	output logic    hsync,
	output logic    vsync
);

	localparam int COLS = 64;
	localparam int ROWS = 16;

	logic [2:0]  sync_a;     // {sck, ss, sdi}
	logic [2:0]  sync_b;
	logic        sck_prev;
	logic        sck_rise;
	logic [6:0]  shift;
	logic [2:0]  bit_cnt;
	logic        first_byte;
	logic        loading;
	logic [3:0]  load_row;
	logic [3:0]  load_cnt;
	logic        show;
	logic        data_wr;
	osd_byte_u   rx;
	logic [63:0] bitmap [0:ROWS-1];
	logic [9:0]  hx;
	logic [9:0]  vy;
	logic        in_window;
	logic        pix_bit;
	rgb555_t     mix;

	assign sck_rise = sync_b[2] && !sck_prev;
	assign rx.data  = {shift, sync_b[0]};  // completed byte, MSB first
	assign data_wr  = sck_rise && !sync_b[1] && (bit_cnt == 3'd7) && !first_byte && loading;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_a   <= 3'b010;
			sync_b   <= 3'b010;
			sck_prev <= 1'b0;
		end else begin
			sync_a   <= {sck, ss, sdi};
			sync_b   <= sync_a;
			sck_prev <= sync_b[2];
		end
	end

	always_ff @(posedge clk) begin
		if (reset || sync_b[1]) begin  // ss high ends a transfer
			bit_cnt    <= '0;
			first_byte <= 1'b1;
			loading    <= 1'b0;
		end else if (sck_rise) begin
			shift   <= {shift[5:0], sync_b[0]};
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				first_byte <= 1'b0;
				if (first_byte && rx.cmd.opcode == OSD_OP_LOAD) begin
					loading  <= 1'b1;
					load_row <= rx.cmd.row;
					load_cnt <= '0;
				end else if (data_wr) begin
					load_cnt <= load_cnt + 4'd1;
					loading  <= (load_cnt != 4'd7);  // eight bytes fill one row
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			show <= 1'b0;
		end else if (sck_rise && !sync_b[1] && bit_cnt == 3'd7 && first_byte &&
		             rx.cmd.opcode == OSD_OP_SHOW) begin
			show <= rx.cmd.row[0];
		end
	end

	always_ff @(posedge clk) begin
		if (data_wr) begin
			bitmap[load_row][63 - 8 * int'(load_cnt[2:0]) -: 8] <= rx.data;  // leftmost byte first
		end
	end

	assign hx = raster_in.h - 10'(`OSD_X0);
	assign vy = raster_in.v - 10'(`OSD_Y0);
	assign in_window = (raster_in.h >= 10'(`OSD_X0)) &&
	                   (raster_in.h < 10'(`OSD_X0 + COLS * `OSD_SCALE)) &&
	                   (raster_in.v >= 10'(`OSD_Y0)) &&
	                   (raster_in.v < 10'(`OSD_Y0 + ROWS * `OSD_SCALE));
	assign pix_bit = bitmap[4'(vy / 10'(`OSD_SCALE))][63 - int'(6'(hx / 10'(`OSD_SCALE)))];

	always_comb begin
		mix = rgb_in;
		if (show && in_window) begin
			if (pix_bit) begin
				mix = 15'h7FFF;
			end else begin
				mix = '{blue: rgb_in.blue >> 1, green: rgb_in.green >> 1,
				        red: rgb_in.red >> 1};  // dimmed picture behind the text
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			rgb   <= raster_in.visible ? mix : rgb555_t'(15'h0000);
			hsync <= raster_in.hsync;
			vsync <= raster_in.vsync;
		end
	end

	// a row takes exactly eight data bytes
	a_load_len: assert property (
		@(posedge clk) disable iff (reset) data_wr |-> (load_cnt < 4'd8)
	);

endmodule

/* rtl/osd_pkg.sv */
// --------------------------------------------------------------------------
// OSD serial command format: opcodes, command byte and byte decode union
// --------------------------------------------------------------------------
package osd_pkg;

	localparam logic [3:0] OSD_OP_SHOW = 4'd1;  // row[0] switches the window on/off
	localparam logic [3:0] OSD_OP_LOAD = 4'd2;  // followed by 8 data bytes

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] row;
	} osd_cmd_t;

	// first byte of a transfer is a command, the rest are bitmap data
	typedef union packed {
		osd_cmd_t   cmd;
		logic [7:0] data;
	} osd_byte_u;

endpackage

/* rtl/video_pkg.sv */
// --------------------------------------------------------------------------
// video types: RGB555 pixel, PPU pixel strobe and VGA raster position
// --------------------------------------------------------------------------
package video_pkg;

	typedef struct packed {
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} rgb555_t;

	typedef struct packed {
		logic       valid;  // pixel strobe
		logic [5:0] index;  // palette index
		logic [7:0] x;
		logic [7:0] line;
	} ppu_pixel_t;

	typedef struct packed {
		logic [9:0] h;
		logic [9:0] v;
		logic       visible;
		logic       hsync;  // active low
		logic       vsync;  // active low
	} raster_t;

endpackage

/* rtl/video_settings.svh */
// --------------------------------------------------------------------------
// video output settings: VGA raster geometry, line buffers and OSD window
// --------------------------------------------------------------------------
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// horizontal raster, in clocks
`define H_TOTAL      682
`define H_VISIBLE    512
`define HS_START     570
`define HS_WIDTH     82

// vertical raster, in lines
`define V_TOTAL      524
`define V_VISIBLE    480
`define VS_START     490
`define VS_WIDTH     2

`define LINE_BUFFERS 2    // one per PPU line parity
`define PPU_WIDTH    256  // pixels per PPU line

`define OSD_X0       128  // window corner in VGA pixels
`define OSD_Y0       176
`define OSD_SCALE    4    // VGA pixels per bitmap pixel

`endif

/* rtl/video_timing.sv */
// --------------------------------------------------------------------------
// VGA timing: 682 x 524 raster counters with frame restart and syncs
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module video_timing
	import video_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    frame_start,
	output raster_t raster
);

	logic [9:0] h;
	logic [9:0] v;
	logic       h_end;

	assign h_end = (h == 10'(`H_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (reset || frame_start) begin  // PPU frame pulse realigns the raster
			h <= '0;
			v <= '0;
		end else if (h_end) begin
			h <= '0;
			v <= (v == 10'(`V_TOTAL - 1)) ? 10'd0 : v + 10'd1;
		end else begin
			h <= h + 10'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			raster <= '{h: '0, v: '0, visible: 1'b0, hsync: 1'b1, vsync: 1'b1};
		end else begin
			raster.h       <= h;
			raster.v       <= v;
			raster.visible <= (h < 10'(`H_VISIBLE)) && (v < 10'(`V_VISIBLE));
			raster.hsync   <= !((h >= 10'(`HS_START)) &&
			                    (h < 10'(`HS_START + `HS_WIDTH)));
			raster.vsync   <= !((v >= 10'(`VS_START)) &&
			                    (v < 10'(`VS_START + `VS_WIDTH)));
		end
	end

	// the published line number must stay within one frame
	a_v_range: assert property (
		@(posedge clk) disable iff (reset) raster.v < 10'(`V_TOTAL)
	);

endmodule

/* test/nes_video_tb.sv */
// --------------------------------------------------------------------------
// NES video testbench: raster, palette, scan doubling, blanking and OSD
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "video_settings.svh"

module nes_video_tb
	import video_pkg::*;
();

	localparam int FRAME_LIMIT = `H_TOTAL * `V_TOTAL + 1000;
	localparam int LINE_LIMIT  = `H_TOTAL + 100;

	logic        clk;
	logic        reset;
	logic        frame_start;
	logic        sck;
	logic        ss;
	logic        sdi;
	ppu_pixel_t  ppu;
	logic        hsync;
	logic        vsync;
	rgb555_t     rgb;

	logic [15:0] lfsr;
	int          test_errors;
	bit          aborted;

	nes_video i_nes_video (
		.clk, .reset, .frame_start, .sck, .ss, .sdi, .ppu, .hsync, .vsync, .rgb
	);

	always #10 clk = ~clk;  // 20 ns period

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_random_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic serial_half_period();
		int extra;
		take_random_bits(3, extra);
		repeat (3 + extra) @(negedge clk);  // 3..10 clocks, slower than the 2-flop sync
	endtask

	task automatic send_byte(input logic [7:0] value);
		for (int b = 7; b >= 0; b--) begin  // MSB first
			sdi = value[b];
			serial_half_period();
			sck = 1'b1;
			serial_half_period();
			sck = 1'b0;
		end
	endtask

	task automatic send_transfer(input logic [7:0] cmd, input logic [63:0] bits);
		ss = 1'b0;
		serial_half_period();
		send_byte(cmd);
		if (cmd[7:4] == 4'h2) begin  // load row takes eight bytes, leftmost first
			for (int i = 0; i < 8; i++) begin
				send_byte(bits[63 - 8 * i -: 8]);
			end
		end
		serial_half_period();
		ss = 1'b1;
		serial_half_period();
	endtask

	task automatic fill_line(input int y, input logic [5:0] base, input logic [5:0] step);
		for (int x = 0; x < `PPU_WIDTH; x++) begin
			ppu = '{valid: 1'b1, index: base + step * 6'(x), x: 8'(x), line: 8'(y)};
			@(negedge clk);
		end
		ppu.valid = 1'b0;
	endtask

	// vertical selects vsync, else hsync; returns once the signal changes to level
	task automatic wait_sync_edge(input bit vertical, input logic level, input int limit,
	                              output int cycles);
		logic prev;
		logic now;
		cycles = 0;
		if (aborted) return;
		prev = vertical ? vsync : hsync;
		while (cycles < limit) begin
			@(negedge clk);
			cycles++;
			now = vertical ? vsync : hsync;
			if (prev != level && now == level) return;
			prev = now;
		end
		aborted = 1'b1;
		$display("timeout: %0s did not go %0s within %0d clocks",
			vertical ? "vsync" : "hsync", level ? "high" : "low", limit);
	endtask

	task automatic check_value(input string name, input string what, input int expected,
	                           input int actual);
		assert (actual == expected) else begin
			$display("ERR %0s %0s expected %0h actual %0h", name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_raster(input string name);
		int low;
		int high;
		int dummy;
		wait_sync_edge(1'b1, 1'b0, FRAME_LIMIT, dummy);
		wait_sync_edge(1'b1, 1'b1, FRAME_LIMIT, low);
		if (!aborted) begin
			check_value(name, "vsync low clocks", `VS_WIDTH * `H_TOTAL, low);
		end
		wait_sync_edge(1'b0, 1'b0, LINE_LIMIT, dummy);
		wait_sync_edge(1'b0, 1'b1, LINE_LIMIT, low);
		wait_sync_edge(1'b0, 1'b0, LINE_LIMIT, high);
		if (!aborted) begin
			check_value(name, "hsync low clocks", `HS_WIDTH, low);
			check_value(name, "line clocks", `H_TOTAL, low + high);
		end
	endtask

	// probes pixels px, px+1 on lines py, py+1; px must stay below HS_START - 1
	task automatic probe_block(input string name, input int px, input int py,
	                           input logic [14:0] expected);
		int falls;
		int dummy;
		falls = (py - (`VS_START + 1) + `V_TOTAL) % `V_TOTAL + 1;  // first fall is on VS_START
		wait_sync_edge(1'b1, 1'b0, FRAME_LIMIT, dummy);
		for (int line = 0; line < 2; line++) begin
			repeat (line == 0 ? falls : 1) begin
				wait_sync_edge(1'b0, 1'b0, LINE_LIMIT, dummy);
			end
			if (aborted) return;
			// syncs and rgb share the 4-clock pipeline, so only the counter distance counts
			repeat (`H_TOTAL - `HS_START + px) @(negedge clk);
			check_value(name, $sformatf("pixel %0d,%0d", px, py + line),
				int'(expected), int'(rgb));
			@(negedge clk);
			check_value(name, $sformatf("pixel %0d,%0d", px + 1, py + line),
				int'(expected), int'(rgb));
		end
	endtask

	initial begin
		int          fd;
		int          count;
		int          tests;
		int          failed;
		int          kind;
		int          px;
		int          py;
		string       text;
		string       name;
		logic [7:0]  base;
		logic [7:0]  step;
		logic [7:0]  cmd_a;
		logic [7:0]  cmd_b;
		logic [63:0] bits;
		logic [15:0] expected;

		clk         = 1'b0;
		reset       = 1'b1;
		frame_start = 1'b0;
		sck         = 1'b0;
		ss          = 1'b1;
		sdi         = 1'b0;
		ppu         = '0;
		lfsr        = 16'd99;
		aborted     = 1'b0;
		tests       = 0;
		failed      = 0;

		repeat (2) @(negedge clk);
		reset       = 1'b0;
		frame_start = 1'b1;  // realign the raster once
		@(negedge clk);
		frame_start = 1'b0;

		fd = $fopen("test/nes_video_testdata.txt", "r");
		if (fd == 0) begin
			aborted = 1'b1;
			$display("cannot open test/nes_video_testdata.txt");
		end
		while (!aborted && !$feof(fd)) begin
			text = "";
			void'($fgets(text, fd));
			count = $sscanf(text, "%d %s %h %h %d %d %h %h %h %h", kind, name, base, step,
				px, py, cmd_a, cmd_b, bits, expected);
			if (count != 10) continue;  // header or blank line
			test_errors = 0;
			if (kind == 0) begin
				check_raster(name);
			end else begin
				if (base != 8'hFF) begin  // FF keeps the stored line
					fill_line(py / 2, base[5:0], step[5:0]);
				end
				if (cmd_a != 8'h00) begin
					send_transfer(cmd_a, bits);
				end
				if (cmd_b != 8'h00) begin
					send_transfer(cmd_b, bits);
				end
				probe_block(name, px, py, expected[14:0]);
			end
			tests++;
			if (aborted) begin
				failed++;
				$display("%0s stopped", name);
			end else if (test_errors != 0) begin
				failed++;
				$display("%0s failed with %0d errors", name, test_errors);
			end else begin
				$display("%0s passed", name);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("tests %0d, failed %0d", tests, failed);
		if (!aborted && failed == 0 && tests > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* test/nes_video_testdata.txt */
// kind name base step px py cmd_a cmd_b row_bits expected_rgb555
// kind 0 is raster timing; kind 1 fills PPU line py/2 unless base is FF and probes a 2x2 block
0 raster        00 00   0   0 00 00 0000000000000000 0000
1 palette_21    21 00 200  40 00 00 0000000000000000 7EE7
1 palette_2a    2A 00  64 100 00 00 0000000000000000 2B6B
1 doubling_even 03 05  74 120 00 00 0000000000000000 7FE0
1 doubling_odd  03 05 400 122 00 00 0000000000000000 4FEB
1 doubling_last 07 03 510 238 00 00 0000000000000000 4012
1 blank_right   30 00 540 300 00 00 0000000000000000 0000
1 blank_bottom  30 00 100 496 00 00 0000000000000000 0000
1 osd_white     16 00 128 176 11 20 F0F0F0F0F0F0F0F0 7FFF
1 osd_dim       FF 00 144 176 00 00 0000000000000000 006F
1 osd_off_dim   FF 00 144 176 10 00 0000000000000000 00FF
1 osd_off_white FF 00 128 176 00 00 0000000000000000 00FF
